// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // line and burst geometry
    localparam int LINE_BITS      = 256;                    // one cache line
    localparam int BURST_BITS     = 64;                     // one bmem beat
    localparam int BEATS_PER_LINE = LINE_BITS / BURST_BITS; // beats per line transfer

    // word request from a requester to its first-level cache
    typedef struct packed {
        logic [31:0] addr;      // byte address
        logic        read;
        logic        write;
        logic [3:0]  wmask;     // byte enables for writes
        logic [31:0] wdata;
    } word_req_t;

    // line request from a cache toward memory
    typedef struct packed {
        logic [31:0]          addr;  // line aligned
        logic                 read;
        logic                 write;
        logic [LINE_BITS-1:0] wdata; // victim line on write-back
    } line_req_t;

endpackage

`default_nettype wire

// ==== verilog/l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

// direct-mapped write-back cache, 32-bit words against 256-bit lines
module l1_cache #(
    parameter int SET_BITS = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  mem_pkg::word_req_t            req_i,
    output logic [31:0]                   rdata_o,
    output logic                          resp_o,
    output mem_pkg::line_req_t            line_req_o,
    input  logic [mem_pkg::LINE_BITS-1:0] line_rdata_i,
    input  logic                          line_resp_i
);

    localparam int SETS       = 1 << SET_BITS;
    localparam int LINE_BYTES = mem_pkg::LINE_BITS / 8;
    localparam int OFF_BITS   = $clog2(LINE_BYTES);           // byte offset in line
    localparam int WSEL_BITS  = $clog2(mem_pkg::LINE_BITS / 32); // word offset in line
    localparam int TAG_BITS   = 32 - SET_BITS - OFF_BITS;

    localparam logic [1:0] S_CMP   = 2'd0; // tag compare, hit service
    localparam logic [1:0] S_WB    = 2'd1; // dirty victim write-back
    localparam logic [1:0] S_ALLOC = 2'd2; // line fetch

    logic [1:0]                   state_q;
    logic [TAG_BITS-1:0]          tag_q [SETS];
    logic [SETS-1:0]              valid_q;
    logic [SETS-1:0]              dirty_q;
    logic [mem_pkg::LINE_BITS-1:0] data_q [SETS];

    logic [TAG_BITS-1:0]           req_tag;
    logic [SET_BITS-1:0]           req_idx;
    logic [WSEL_BITS-1:0]          req_wsel;
    logic [mem_pkg::LINE_BITS-1:0] cur_line;
    logic [mem_pkg::LINE_BITS-1:0] wr_data;
    logic [mem_pkg::LINE_BITS-1:0] wr_line;
    logic [LINE_BYTES-1:0]         wr_bmask;
    logic                          active;
    logic                          hit;
    logic                          hit_acc;
    logic                          fill;

    // address split
    assign req_tag  = req_i.addr[31 -: TAG_BITS];
    assign req_idx  = req_i.addr[OFF_BITS +: SET_BITS];
    assign req_wsel = req_i.addr[2 +: WSEL_BITS];

    assign cur_line = data_q[req_idx];

    // a request held during its own resp cycle is not a new one
    assign active  = (req_i.read || req_i.write) && !resp_o;
    assign hit     = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign hit_acc = (state_q == S_CMP) && active && hit;
    assign fill    = (state_q == S_ALLOC) && line_resp_i;

    // word to line shift and byte mask expansion
    assign wr_bmask = LINE_BYTES'(req_i.wmask) << {req_wsel, 2'b00};
    assign wr_data  = mem_pkg::LINE_BITS'(req_i.wdata) << {req_wsel, 5'b00000};

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            wr_line[8*b +: 8] = wr_bmask[b] ? wr_data[8*b +: 8] : cur_line[8*b +: 8];
        end
    end

    // line side request, held by the state
    always_comb begin
        line_req_o.read  = (state_q == S_ALLOC);
        line_req_o.write = (state_q == S_WB);
        line_req_o.wdata = cur_line;               // victim line
        if (state_q == S_WB) begin
            line_req_o.addr = {tag_q[req_idx], req_idx, {OFF_BITS{1'b0}}};
        end else begin
            line_req_o.addr = {req_tag, req_idx, {OFF_BITS{1'b0}}};
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_CMP;
            resp_o  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_o <= 1'b0;
            case (state_q)
                S_CMP: begin
                    if (active) begin
                        if (hit) begin
                            resp_o <= 1'b1;
                            if (req_i.write) begin
                                dirty_q[req_idx] <= 1'b1;
                            end
                        end else if (valid_q[req_idx] && dirty_q[req_idx]) begin
                            state_q <= S_WB;          // evict first
                        end else begin
                            state_q <= S_ALLOC;
                        end
                    end
                end
                S_WB: begin
                    if (line_resp_i) begin
                        state_q <= S_ALLOC;
                    end
                end
                S_ALLOC: begin
                    if (line_resp_i) begin
                        state_q          <= S_CMP; // completes as a hit
                        valid_q[req_idx] <= 1'b1;
                        dirty_q[req_idx] <= 1'b0;
                    end
                end
                default: state_q <= S_CMP;
            endcase
        end
    end

    // tag and line store, read word
    always_ff @(posedge clk) begin
        if (hit_acc) begin
            rdata_o <= cur_line[{req_wsel, 5'b00000} +: 32];
            if (req_i.write) begin
                data_q[req_idx] <= wr_line;   // masked merge
            end
        end
        if (fill) begin
            data_q[req_idx] <= line_rdata_i;
            tag_q[req_idx]  <= req_tag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/line_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// shares the single line path between instruction and data caches
module line_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  mem_pkg::line_req_t            ireq_i,
    input  mem_pkg::line_req_t            dreq_i,
    output logic [mem_pkg::LINE_BITS-1:0] irdata_o,
    output logic [mem_pkg::LINE_BITS-1:0] drdata_o,
    output logic                          iresp_o,
    output logic                          dresp_o,
    output mem_pkg::line_req_t            req_o,
    input  logic [mem_pkg::LINE_BITS-1:0] rdata_i,
    input  logic                          resp_i
);

    localparam logic OWNER_I = 1'b0;
    localparam logic OWNER_D = 1'b1;

    logic busy_q;   // path granted
    logic owner_q;  // who holds the grant
    logic ipend;
    logic dpend;

    assign ipend = ireq_i.read || ireq_i.write;
    assign dpend = dreq_i.read || dreq_i.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= OWNER_I;
        end else if (!busy_q) begin
            if (dpend) begin           // data cache first
                busy_q  <= 1'b1;
                owner_q <= OWNER_D;
            end else if (ipend) begin
                busy_q  <= 1'b1;
                owner_q <= OWNER_I;
            end
        end else if (resp_i) begin
            busy_q <= 1'b0;           // release on line done
        end
    end

    // granted request out, strobes only while busy
    always_comb begin
        req_o       = (owner_q == OWNER_D) ? dreq_i : ireq_i;
        req_o.read  = req_o.read && busy_q;
        req_o.write = req_o.write && busy_q;
    end

    assign irdata_o = rdata_i;
    assign drdata_o = rdata_i;

    // resp goes back to the owner only
    assign iresp_o = resp_i && busy_q && (owner_q == OWNER_I);
    assign dresp_o = resp_i && busy_q && (owner_q == OWNER_D);

endmodule

`default_nettype wire

// ==== verilog/cacheline_adaptor.sv ====
`timescale 1ns/1ps
`default_nettype none

// line transfers as four 64-bit bursts on bmem
module cacheline_adaptor (
    input  logic                           clk,
    input  logic                           rst,
    input  mem_pkg::line_req_t             req_i,
    output logic [mem_pkg::LINE_BITS-1:0]  rdata_o,
    output logic                           resp_o,
    output logic [31:0]                    bmem_addr_o,
    output logic                           bmem_read_o,
    output logic                           bmem_write_o,
    output logic [mem_pkg::BURST_BITS-1:0] bmem_wdata_o,
    input  logic [mem_pkg::BURST_BITS-1:0] bmem_rdata_i,
    input  logic                           bmem_resp_i
);

    localparam int BEAT_W = $clog2(mem_pkg::BEATS_PER_LINE);

    localparam logic [1:0] A_IDLE  = 2'd0;
    localparam logic [1:0] A_READ  = 2'd1;
    localparam logic [1:0] A_WRITE = 2'd2;

    logic [1:0]                    state_q;
    logic [BEAT_W-1:0]             beat_q;
    logic                          done_q;
    logic [31:0]                   addr_q;
    logic [mem_pkg::LINE_BITS-1:0] buf_q;   // line shift register
    logic                          start_rd;
    logic                          start_wr;
    logic                          busy;
    logic                          last_beat;

    // done_q masks the request still held in the resp cycle
    assign start_rd  = (state_q == A_IDLE) && !done_q && req_i.read;
    assign start_wr  = (state_q == A_IDLE) && !done_q && req_i.write && !req_i.read;
    assign busy      = (state_q == A_READ) || (state_q == A_WRITE);
    assign last_beat = busy && bmem_resp_i && (beat_q == BEAT_W'(mem_pkg::BEATS_PER_LINE - 1));

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= A_IDLE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= last_beat;              // resp one cycle after 4th beat
            if (start_rd) begin
                state_q <= A_READ;
                beat_q  <= '0;
            end else if (start_wr) begin
                state_q <= A_WRITE;
                beat_q  <= '0;
            end else if (busy && bmem_resp_i) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    state_q <= A_IDLE;
                end
            end
        end
    end

    // address and line data
    always_ff @(posedge clk) begin
        if (start_rd || start_wr) begin
            addr_q <= req_i.addr;
        end
        if (start_wr) begin
            buf_q <= req_i.wdata;
        end else if (busy && bmem_resp_i) begin
            // lowest beat first in both directions
            buf_q <= {bmem_rdata_i, buf_q[mem_pkg::LINE_BITS-1:mem_pkg::BURST_BITS]};
        end
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == A_READ);
    assign bmem_write_o = (state_q == A_WRITE);
    assign bmem_wdata_o = buf_q[mem_pkg::BURST_BITS-1:0]; // current beat

    assign rdata_o = buf_q;
    assign resp_o  = done_q;

endmodule

`default_nettype wire

// ==== verilog/mem_hier.sv ====
`timescale 1ns/1ps
`default_nettype none

// two L1 caches, line arbiter and burst adaptor
module mem_hier #(
    parameter int SET_BITS = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  mem_pkg::word_req_t             imem_req_i,
    output logic [31:0]                    imem_rdata_o,
    output logic                           imem_resp_o,
    input  mem_pkg::word_req_t             dmem_req_i,
    output logic [31:0]                    dmem_rdata_o,
    output logic                           dmem_resp_o,
    output logic [31:0]                    bmem_addr_o,
    output logic                           bmem_read_o,
    output logic                           bmem_write_o,
    output logic [mem_pkg::BURST_BITS-1:0] bmem_wdata_o,
    input  logic [mem_pkg::BURST_BITS-1:0] bmem_rdata_i,
    input  logic                           bmem_resp_i
);

    mem_pkg::line_req_t            iline_req;  // icache -> arb
    mem_pkg::line_req_t            dline_req;  // dcache -> arb
    mem_pkg::line_req_t            mline_req;  // arb -> adaptor
    logic [mem_pkg::LINE_BITS-1:0] iline_rdata;
    logic [mem_pkg::LINE_BITS-1:0] dline_rdata;
    logic [mem_pkg::LINE_BITS-1:0] mline_rdata;
    logic                          iline_resp;
    logic                          dline_resp;
    logic                          mline_resp;

    l1_cache #(
        .SET_BITS (SET_BITS)
    ) icache (
        .clk          (clk),
        .rst          (rst),
        .req_i        (imem_req_i),
        .rdata_o      (imem_rdata_o),
        .resp_o       (imem_resp_o),
        .line_req_o   (iline_req),
        .line_rdata_i (iline_rdata),
        .line_resp_i  (iline_resp)
    );

    l1_cache #(
        .SET_BITS (SET_BITS)
    ) dcache (
        .clk          (clk),
        .rst          (rst),
        .req_i        (dmem_req_i),
        .rdata_o      (dmem_rdata_o),
        .resp_o       (dmem_resp_o),
        .line_req_o   (dline_req),
        .line_rdata_i (dline_rdata),
        .line_resp_i  (dline_resp)
    );

    line_arbiter arb (
        .clk      (clk),
        .rst      (rst),
        .ireq_i   (iline_req),
        .dreq_i   (dline_req),
        .irdata_o (iline_rdata),
        .drdata_o (dline_rdata),
        .iresp_o  (iline_resp),
        .dresp_o  (dline_resp),
        .req_o    (mline_req),
        .rdata_i  (mline_rdata),
        .resp_i   (mline_resp)
    );

    cacheline_adaptor adaptor (
        .clk          (clk),
        .rst          (rst),
        .req_i        (mline_req),
        .rdata_o      (mline_rdata),
        .resp_o       (mline_resp),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule

`default_nettype wire

// ==== tests/mem_hier_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// bmem and resp protocol checks
module mem_hier_chk (
    input logic clk,
    input logic rst,
    input logic bmem_read_i,
    input logic bmem_write_i,
    input logic imem_resp_i,
    input logic dmem_resp_i
);

    int unsigned fail_count = 0;  // failed assertions so far

    strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_i && bmem_write_i))
        else begin
            fail_count++;
            $error("bmem read and write strobes high together");
        end

    // a resp lasts one cycle
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        !($past(imem_resp_i) && imem_resp_i) && !($past(dmem_resp_i) && dmem_resp_i))
        else begin
            fail_count++;
            $error("resp held high for more than one cycle");
        end

    resp_in_reset: assert property (@(posedge clk)
        rst |=> (!imem_resp_i && !dmem_resp_i))
        else begin
            fail_count++;
            $error("resp high during reset");
        end

endmodule

bind mem_hier mem_hier_chk chk0 (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_i  (bmem_read_o),
    .bmem_write_i (bmem_write_o),
    .imem_resp_i  (imem_resp_o),
    .dmem_resp_i  (dmem_resp_o)
);

`default_nettype wire

// ==== tests/tb_mem_hier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hier;

    localparam int          SET_BITS     = 3;
    localparam int          RESP_TIMEOUT = 500;       // cycles allowed per request
    localparam int          MEM_WORDS    = 1024;      // 8 KiB of 64-bit words
    localparam logic [15:0] LFSR_SEED    = 16'd11320;

    logic                           clk;
    logic                           rst;
    mem_pkg::word_req_t             imem_req;
    mem_pkg::word_req_t             dmem_req;
    logic [31:0]                    imem_rdata;
    logic                           imem_resp;
    logic [31:0]                    dmem_rdata;
    logic                           dmem_resp;
    logic [31:0]                    bmem_addr;
    logic                           bmem_read;
    logic                           bmem_write;
    logic [mem_pkg::BURST_BITS-1:0] bmem_wdata;
    logic [mem_pkg::BURST_BITS-1:0] bmem_rdata;
    logic                           bmem_resp;

    logic [63:0]        mem [MEM_WORDS];      // backing memory model
    logic [7:0]         image [8*MEM_WORDS];  // expected byte image
    mem_pkg::word_req_t i_issue;              // request in flight per port
    mem_pkg::word_req_t d_issue;
    logic               i_outstanding;
    logic               d_outstanding;
    int                 i_issued;
    int                 i_answered;
    int                 d_issued;
    int                 d_answered;
    logic [15:0]        stim_lfsr;
    logic [15:0]        model_lfsr;
    logic [1:0]         model_beat;
    int                 model_wait;           // -1 while no delay is drawn

    mem_hier #(
        .SET_BITS (SET_BITS)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .imem_req_i   (imem_req),
        .imem_rdata_o (imem_rdata),
        .imem_resp_o  (imem_resp),
        .dmem_req_i   (dmem_req),
        .dmem_rdata_o (dmem_rdata),
        .dmem_resp_o  (dmem_resp),
        .bmem_addr_o  (bmem_addr),
        .bmem_read_o  (bmem_read),
        .bmem_write_o (bmem_write),
        .bmem_wdata_o (bmem_wdata),
        .bmem_rdata_i (bmem_rdata),
        .bmem_resp_i  (bmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            s = lfsr_next(s);                 // one step per bit
            v = {v[30:0], s[0]};
        end
    endtask

    // unique word per address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[31:16] ^ a[15:0], a[15:0]} ^ 32'h9E37_79B9;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [12:0] a;
        a = {addr[12:2], 2'b00};
        return {image[a + 13'd3], image[a + 13'd2], image[a + 13'd1], image[a]};
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [63:0] w;
        w = mem[addr[12:3]];
        return addr[2] ? w[63:32] : w[31:0];
    endfunction

    task automatic apply_write(input mem_pkg::word_req_t r);
        for (int b = 0; b < 4; b++) begin
            if (r.wmask[b]) begin
                image[{r.addr[12:2], 2'(b)}] = r.wdata[8*b +: 8];
            end
        end
    endtask

    task automatic preload();
        logic [31:0] lo;
        logic [31:0] hi;
        for (int w = 0; w < MEM_WORDS; w++) begin
            lo = fill_word(32'(8 * w));
            hi = fill_word(32'(8 * w + 4));
            mem[10'(w)] = {hi, lo};
            for (int b = 0; b < 4; b++) begin
                image[13'(8 * w + b)]     = lo[8*b +: 8];
                image[13'(8 * w + 4 + b)] = hi[8*b +: 8];
            end
        end
    endtask

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_on_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("[FAIL] time %0t: %s = %h, expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic stop_on_error(input string what);
        $display("[ERROR] time %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic wait_for_resp(input logic data_port, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > RESP_TIMEOUT) begin
                stop_on_error(data_port ? "data request got no resp" :
                                          "instruction request got no resp");
            end
        end while (!(data_port ? dmem_resp : imem_resp));
    endtask

    task automatic data_access(input logic [31:0] addr, input logic wr, input logic [3:0] mask,
                               input logic [31:0] wdata, output int cycles);
        d_issue.addr  = {addr[31:2], 2'b00};
        d_issue.read  = !wr;
        d_issue.write = wr;
        d_issue.wmask = wr ? mask : 4'b0000;
        d_issue.wdata = wdata;
        dmem_req      = d_issue;
        d_outstanding = 1'b1;
        d_issued++;
        wait_for_resp(1'b1, cycles);
        dmem_req.read  = 1'b0;                // dropped after resp
        dmem_req.write = 1'b0;
        @(negedge clk);
    endtask

    task automatic inst_read(input logic [31:0] addr);
        int cycles;
        i_issue       = '0;
        i_issue.addr  = {addr[31:2], 2'b00};
        i_issue.read  = 1'b1;
        imem_req      = i_issue;
        i_outstanding = 1'b1;
        i_issued++;
        wait_for_resp(1'b0, cycles);
        imem_req.read = 1'b0;
        @(negedge clk);
    endtask

    // bmem model answers one beat per resp after 0 to 3 idle cycles
    always @(negedge clk) begin : memory_model
        logic [31:0] r;
        logic [9:0]  idx;
        bmem_resp = 1'b0;
        if (rst || !(bmem_read || bmem_write)) begin
            model_beat = 2'd0;
            model_wait = -1;
        end else begin
            if (model_wait < 0) begin
                draw_bits(model_lfsr, 2, r);
                model_wait = int'(r);
            end
            if (model_wait == 0) begin
                idx = {bmem_addr[12:5], model_beat};
                if (bmem_write) begin
                    mem[idx] = bmem_wdata;
                end else begin
                    bmem_rdata = mem[idx];
                end
                bmem_resp  = 1'b1;
                model_beat = model_beat + 2'd1;
                model_wait = -1;
            end else begin
                model_wait--;
            end
        end
    end

    always @(negedge clk) begin : compare_responses
        if (!rst) begin
            assert (dut0.chk0.fail_count == 0)
                else stop_on_error("a bound protocol assertion failed");
            if (dmem_resp) begin
                assert (d_outstanding)
                    else stop_on_error("dmem_resp_o pulsed with no open data request");
                d_outstanding = 1'b0;
                d_answered++;
                if (d_issue.write) begin
                    apply_write(d_issue);
                end else begin
                    assert (dmem_rdata == ref_word(d_issue.addr))
                        else stop_on_value("dmem_rdata_o", dmem_rdata, ref_word(d_issue.addr));
                end
            end
            if (imem_resp) begin
                assert (i_outstanding)
                    else stop_on_error("imem_resp_o pulsed with no open instruction request");
                i_outstanding = 1'b0;
                i_answered++;
                assert (imem_rdata == ref_word(i_issue.addr))
                    else stop_on_value("imem_rdata_o", imem_rdata, ref_word(i_issue.addr));
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_mask;
        logic [31:0] r_data;
        logic [31:0] a_addr;
        logic [31:0] b_addr;
        logic [31:0] wb_addr;
        int          cycles;

        rst           = 1'b1;
        imem_req      = '0;
        dmem_req      = '0;
        bmem_rdata    = '0;
        bmem_resp     = 1'b0;
        i_issue       = '0;
        d_issue       = '0;
        i_outstanding = 1'b0;
        d_outstanding = 1'b0;
        i_issued      = 0;
        i_answered    = 0;
        d_issued      = 0;
        d_answered    = 0;
        stim_lfsr     = LFSR_SEED;
        model_lfsr    = LFSR_SEED;
        model_beat    = 2'd0;
        model_wait    = -1;
        preload();
        repeat (2) @(negedge clk);
        rst = 1'b0;

        repeat (4) begin                      // idle after reset
            @(negedge clk);
            assert (!imem_resp && !dmem_resp && !bmem_read && !bmem_write)
                else stop_on_error("resp or bmem strobe active before any request");
        end

        data_access(32'h0000_0040, 1'b0, 4'h0, 32'h0, cycles);   // miss
        data_access(32'h0000_0044, 1'b0, 4'h0, 32'h0, cycles);   // same line
        assert (cycles == 1)
            else stop_on_value("dmem hit latency", 32'(cycles), 32'd1);

        // two masked writes per word before the read back
        for (int k = 0; k < 8; k++) begin
            draw_bits(stim_lfsr, 4, r_mask);
            draw_bits(stim_lfsr, 32, r_data);
            data_access(32'h0000_0080 + 32'(4 * (k % 4)), 1'b1, r_mask[3:0], r_data, cycles);
        end
        for (int k = 0; k < 4; k++) begin
            data_access(32'h0000_0080 + 32'(4 * k), 1'b0, 4'h0, 32'h0, cycles);
        end

        // same index with a different tag
        a_addr = 32'h0000_0124;
        b_addr = a_addr + 32'h0000_0100;
        data_access(a_addr, 1'b1, 4'hF, 32'hC0DE_5A17, cycles);
        data_access(b_addr, 1'b0, 4'h0, 32'h0, cycles);          // evicts dirty line
        for (int w = 0; w < 8; w++) begin
            wb_addr = {a_addr[31:5], 5'd0} + 32'(4 * w);         // whole victim line
            assert (model_word(wb_addr) == ref_word(wb_addr))
                else stop_on_value("written-back memory word", model_word(wb_addr),
                                   ref_word(wb_addr));
        end
        data_access(b_addr + 32'd4, 1'b1, 4'h3, 32'h1234_5678, cycles);
        data_access(a_addr, 1'b0, 4'h0, 32'h0, cycles);

        fork
            begin
                for (int k = 0; k < 16; k++) begin
                    inst_read(32'h0000_1000 + 32'(36 * k));
                end
            end
            begin
                for (int k = 0; k < 16; k++) begin
                    data_access(32'h0000_0200 + 32'(20 * (k / 2)), !k[0], 4'hF,
                                32'hA5A5_0000 | 32'(k), cycles);
                end
            end
        join
        assert (i_issued == i_answered && d_issued == d_answered)
            else stop_on_error("request and resp counts differ after mixed traffic");

        // small address range keeps sets getting evicted
        for (int k = 0; k < 200; k++) begin
            draw_bits(stim_lfsr, 2, r_op);
            draw_bits(stim_lfsr, 8, r_addr);
            if (r_op[1:0] == 2'd0) begin
                inst_read(32'h0000_1000 + {22'd0, r_addr[7:0], 2'b00});
            end else begin
                draw_bits(stim_lfsr, 4, r_mask);
                draw_bits(stim_lfsr, 32, r_data);
                data_access({22'd0, r_addr[7:0], 2'b00}, r_op[1], r_mask[3:0], r_data, cycles);
            end
        end

        assert (i_issued == i_answered && d_issued == d_answered)
            else stop_on_error("request and resp counts differ at the end");
        if (dut0.chk0.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_error("a bound protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/mem_pkg.sv
verilog/l1_cache.sv
verilog/line_arbiter.sv
verilog/cacheline_adaptor.sv
verilog/mem_hier.sv
tests/mem_hier_chk.sv
tests/tb_mem_hier.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mem_hier -f tb.f \
    && ./obj_dir/Vtb_mem_hier +verilator+error+limit+100 | tee sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
